//--- vlog.f
hdl/realign_pkg.sv
hdl/fetch_predecode.sv
hdl/halfword_realigner.sv
hdl/realign_top.sv
test/tb_clock_gen.sv
test/realign_assertions.sv
test/tb_realign.sv

//--- run.sh
#!/bin/sh
# build and run the realigner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_realign -o sim_realign

# the simulator status is not trusted, the log decides
./obj_dir/sim_realign | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "simulation run passed"
    exit 0
else
    echo "simulation run failed"
    exit 1
fi

//--- test/tb_realign.sv
`timescale 1ns/10ps

module tb_realign;
    import realign_pkg::*;

    // number of random cycles after reset and the cycles from drive to check
    localparam int unsigned NUM_CYCLES = 3000;
    localparam logic [31:0] LATENCY    = 32'd2;

    // one expected instruction together with the check cycle it is due in
    typedef struct packed {
        logic [31:0]     due;
        logic [VLEN-1:0] addr;
        logic [ILEN-1:0] instr;
    } exp_item_t;

    logic         clk;
    logic         rst_n;
    logic         flush;
    logic         valid;
    fetch_req_t   fetch;
    realign_out_t instr;
    logic         serving_unaligned;

    logic [31:0]     lfsr;
    logic [31:0]     cyc;
    logic [VLEN-1:0] next_addr;
    exp_item_t       exp_q[$];
    // reference copy of the straddling half and its address
    logic            model_held;
    logic [15:0]     model_half;
    logic [VLEN-1:0] model_haddr;
    // expected serving_unaligned_o with bit 0 for the next check and bit 1 for the one after
    logic [1:0]      held_pipe;
    // hit counts for aligned full, compressed pair, join, odd target and flush
    int unsigned     hits[5];
    bit              pass_seen;
    bit              fail_seen;

    tb_clock_gen clock_gen_inst (.clk_o(clk), .rst_no(rst_n));

    realign_top realign_top_inst (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .flush_i             (flush),
        .valid_i             (valid),
        .fetch_i             (fetch),
        .instr_o             (instr),
        .serving_unaligned_o (serving_unaligned)
    );

    bind realign_top realign_assertions realign_assertions_inst (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .instr_i             (instr_o),
        .serving_unaligned_i (serving_unaligned_o)
    );

    // ----------------------------------------------------------------------
    // random source and error handling
    // ----------------------------------------------------------------------

    // taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // about half of the halfwords open a full instruction (low bits 11)
    task automatic random_half(output logic [15:0] h);
        logic [31:0] r;
        logic [31:0] kind;
        draw_bits(16, r);
        draw_bits(1, kind);
        h = r[15:0];
        if (kind[0]) begin
            h[1:0] = 2'b11;
        end else if (r[1:0] == 2'b11) begin
            h[1:0] = 2'b01;
        end
    endtask

    task automatic abort_run();
        fail_seen = 1'b1;
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    task automatic push_item(input logic [VLEN-1:0] addr, input logic [ILEN-1:0] ins);
        exp_item_t item;
        item.due   = cyc + LATENCY;
        item.addr  = addr;
        item.instr = ins;
        exp_q.push_back(item);
    endtask

    // a halfword is compressed unless its two low bits are both one
    task automatic model_fetch(input logic [VLEN-1:0] addr, input logic [ILEN-1:0] word);
        logic [15:0]     lo;
        logic [15:0]     hi;
        logic [VLEN-1:0] base;
        logic            take_hi;
        lo      = word[15:0];
        hi      = word[31:16];
        base    = {addr[VLEN-1:2], 2'b00};
        take_hi = 1'b1;
        if (model_held) begin
            push_item(model_haddr, {lo, model_half});
            hits[2]++;
        end else if (addr[1]) begin
            hits[3]++;
        end else if (lo[1:0] != 2'b11) begin
            push_item(base, {16'h0000, lo});
            if (hi[1:0] != 2'b11) hits[1]++;
        end else begin
            push_item(base, word);
            take_hi = 1'b0;
            hits[0]++;
        end
        model_held = 1'b0;
        if (take_hi) begin
            if (hi[1:0] != 2'b11) begin
                push_item(base + 32'd2, {16'h0000, hi});
            end else begin
                model_held  = 1'b1;
                model_half  = hi;
                model_haddr = base + 32'd2;
            end
        end
    endtask

    // outputs are registered, so one ns after the edge they are stable
    task automatic check_outputs();
        exp_item_t item;
        for (int s = 0; s < SLOTS; s++) begin
            if (instr.slot[s].valid) begin
                if (exp_q.size() == 0) begin
                    report_error($sformatf("slot %0d is valid with nothing expected", s));
                end else begin
                    item = exp_q.pop_front();
                    check_equal(cyc, item.due, $sformatf("arrival cycle of slot %0d", s));
                    check_equal(instr.slot[s].addr, item.addr, $sformatf("slot %0d address", s));
                    check_equal(instr.slot[s].instr, item.instr, $sformatf("slot %0d instr", s));
                end
            end
        end
        if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            report_error("an expected instruction did not appear in its cycle");
        end
        check_equal({31'd0, serving_unaligned}, {31'd0, held_pipe[0]}, "serving_unaligned_o");
    endtask

    // one clock that checks what came out and then drives the next inputs
    task automatic run_cycle(input logic stim);
        logic [31:0] r;
        logic [15:0] lo;
        logic [15:0] hi;
        logic        do_flush;
        logic        do_valid;
        @(posedge clk);
        #1;
        check_outputs();
        do_flush = 1'b0;
        do_valid = 1'b0;
        if (stim) begin
            draw_bits(5, r);
            do_flush = (r[4:0] == 5'd0);
            draw_bits(2, r);
            do_valid = (r[1:0] != 2'd0);
        end
        random_half(lo);
        random_half(hi);
        flush              = do_flush;
        valid              = do_valid;
        fetch.addr         = next_addr;
        fetch.data.instr   = {hi, lo};
        if (do_flush) begin
            // the word sampled with the flush is lost and the stream restarts at a new target
            draw_bits(31, r);
            next_addr  = {r[30:0], 1'b0};
            model_held = 1'b0;
            exp_q.delete();
            hits[4]++;
        end else if (do_valid) begin
            model_fetch(fetch.addr, fetch.data.instr);
            next_addr = {fetch.addr[VLEN-1:2] + 30'd1, 2'b00};
        end
        held_pipe = {model_held, held_pipe[1] & ~do_flush};
        cyc       = cyc + 32'd1;
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------

    initial begin
        int unsigned wait_cycles;
        flush       = 1'b0;
        valid       = 1'b0;
        fetch       = '0;
        lfsr        = 32'hb1edcd8d;
        cyc         = '0;
        next_addr   = 32'h0000_1000;
        model_held  = 1'b0;
        model_half  = '0;
        model_haddr = '0;
        held_pipe   = '0;
        pass_seen   = 1'b0;
        fail_seen   = 1'b0;
        foreach (hits[i]) hits[i] = 0;
        wait_cycles = 0;
        while (rst_n !== 1'b1) begin
            if (wait_cycles > 50) begin
                report_error("reset was not released within 50 cycles");
            end else begin
                @(posedge clk);
                wait_cycles++;
            end
        end
        repeat (NUM_CYCLES) run_cycle(1'b1);
        foreach (hits[i]) begin
            if (hits[i] == 0) report_error($sformatf("stimulus never hit case %0d", i));
        end
        // let the last fetches leave the pipeline
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 10) begin
            run_cycle(1'b0);
            wait_cycles++;
        end
        if (exp_q.size() == 0) begin
            repeat (4) run_cycle(1'b0);
            pass_seen = 1'b1;
            $display("Verification passed");
            $finish;
        end else begin
            report_error("timed out waiting for the pipeline to drain");
        end
    end

    final begin
        if (!pass_seen && !fail_seen) begin
            $display("Verification failed");
        end
    end

endmodule

//--- test/realign_assertions.sv
`timescale 1ns/10ps

module realign_assertions (
    input logic                      clk_i,
    input logic                      rst_ni,
    input logic                      flush_i,
    input realign_pkg::realign_out_t instr_i,
    input logic                      serving_unaligned_i
);
    // valid bits of the two output slots
    logic slot0_valid;
    logic slot1_valid;

    assign slot0_valid = instr_i.slot[0].valid;
    assign slot1_valid = instr_i.slot[1].valid;

    // an edge taken in reset leaves both slots empty one cycle later
    reset_clears_slots: assert property (@(posedge clk_i)
        !rst_ni |=> (!slot0_valid && !slot1_valid))
        else $error("an output slot was valid right after reset");

    // slots fill in program order, so slot 1 never stands alone
    slot_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
        slot1_valid |-> slot0_valid)
        else $error("slot 1 was valid while slot 0 was empty");

    // a flush edge empties the outputs and drops the held half
    flush_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> (!slot0_valid && !slot1_valid && !serving_unaligned_i))
        else $error("outputs or held half survived a flush");

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);
    // 10 ns period, free running from time zero
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset stays low for ten rising edges and lets go between edges
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- hdl/realign_top.sv
`timescale 1ns/10ps

module realign_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      valid_i,
    input  realign_pkg::fetch_req_t   fetch_i,
    output realign_pkg::realign_out_t instr_o,
    output logic                      serving_unaligned_o
);
    import realign_pkg::*;

    // ----------------------------------------------------------------------
    // stage 1 to stage 2
    // ----------------------------------------------------------------------

    // registered fetch word with its per-halfword compressed flags
    predec_t predec;

    // stage 1 samples every strobed word, there is no stall path, so the
    // fetch unit must never present more than one word per cycle
    fetch_predecode fetch_predecode_inst (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .flush_i  (flush_i),
        .valid_i  (valid_i),
        .fetch_i  (fetch_i),
        .predec_o (predec)
    );

    // ----------------------------------------------------------------------
    // stage 2 and outputs
    // ----------------------------------------------------------------------

    // stage 2 splits the word into up to two instructions and keeps the
    // lower half of an instruction that continues into the next word
    // both stages see the same flush, which empties the whole pipeline
    // in one edge
    halfword_realigner halfword_realigner_inst (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .predec_i            (predec),
        .instr_o             (instr_o),
        .serving_unaligned_o (serving_unaligned_o)
    );

endmodule

//--- hdl/halfword_realigner.sv
`timescale 1ns/10ps

module halfword_realigner (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  realign_pkg::predec_t      predec_i,
    output realign_pkg::realign_out_t instr_o,
    output logic                      serving_unaligned_o
);
    import realign_pkg::*;

    // lower half of a full instruction that crossed into the next word
    logic              held_q,      held_d;
    logic [HALF_W-1:0] held_half_q, held_half_d;
    logic [VLEN-1:0]   held_addr_q, held_addr_d;

    // next value of both output slots
    realign_out_t slot_d;

    // output registers, valid bits apart from the payload
    logic [SLOTS-1:0]           slot_valid_q;
    logic [SLOTS-1:0][VLEN-1:0] slot_addr_q;
    logic [SLOTS-1:0][ILEN-1:0] slot_instr_q;

    // fields of the current stage 1 word
    logic [VLEN-1:0]   base_addr;
    logic [VLEN-1:0]   upper_addr;
    logic [HALF_W-1:0] lower_half;
    logic [HALF_W-1:0] upper_half;

    // the upper halfword still needs a decision
    logic take_upper;
    // index of the next free output slot
    logic fill_idx;

    function automatic instr_slot_t make_slot(input logic [VLEN-1:0] addr,
                                              input logic [ILEN-1:0] instr);
        instr_slot_t s;
        s.valid = 1'b1;
        s.addr  = addr;
        s.instr = instr;
        return s;
    endfunction

    // the word base drops bit 1, the upper halfword sits two bytes above it
    assign base_addr  = {predec_i.addr[VLEN-1:2], 1'b0, predec_i.addr[0]};
    assign upper_addr = {predec_i.addr[VLEN-1:2], 1'b1, predec_i.addr[0]};
    assign lower_half = predec_i.data.half[0];
    assign upper_half = predec_i.data.half[1];

    // ----------------------------------------------------------------------
    // realignment
    // ----------------------------------------------------------------------

    always_comb begin
        slot_d      = '0;
        held_d      = held_q;
        held_half_d = held_half_q;
        held_addr_d = held_addr_q;
        take_upper  = 1'b0;
        fill_idx    = 1'b0;

        if (predec_i.valid) begin
            if (held_q) begin
                // the lower half completes the instruction that started in
                // the previous word, it keeps the address of its first half
                slot_d.slot[0] = make_slot(held_addr_q, {lower_half, held_half_q});
                fill_idx       = 1'b1;
                take_upper     = 1'b1;
            end else if (predec_i.addr[1]) begin
                // jump into the middle of the word, the lower half is not ours
                take_upper = 1'b1;
            end else if (predec_i.half_compressed[0]) begin
                slot_d.slot[0] = make_slot(base_addr, {{(ILEN-HALF_W){1'b0}}, lower_half});
                fill_idx       = 1'b1;
                take_upper     = 1'b1;
            end else begin
                // aligned full instruction fills the whole word
                slot_d.slot[0] = make_slot(base_addr, predec_i.data.instr);
                held_d         = 1'b0;
            end

            // the upper halfword is either a complete compressed instruction
            // or the start of one that continues in the next fetch
            if (take_upper) begin
                if (predec_i.half_compressed[1]) begin
                    slot_d.slot[fill_idx] =
                        make_slot(upper_addr, {{(ILEN-HALF_W){1'b0}}, upper_half});
                    held_d = 1'b0;
                end else begin
                    held_d      = 1'b1;
                    held_half_d = upper_half;
                    held_addr_d = upper_addr;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // state and output registers
    // ----------------------------------------------------------------------

    // a flush drops the item in this stage as well as any held half
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            held_q       <= 1'b0;
            slot_valid_q <= '0;
        end else if (flush_i) begin
            held_q       <= 1'b0;
            slot_valid_q <= '0;
        end else begin
            held_q <= held_d;
            for (int i = 0; i < SLOTS; i++) begin
                slot_valid_q[i] <= slot_d.slot[i].valid;
            end
        end
    end

    // payload follows the stage 1 word and is only looked at when valid
    always_ff @(posedge clk_i) begin
        if (predec_i.valid) begin
            held_half_q <= held_half_d;
            held_addr_q <= held_addr_d;
            for (int i = 0; i < SLOTS; i++) begin
                slot_addr_q[i]  <= slot_d.slot[i].addr;
                slot_instr_q[i] <= slot_d.slot[i].instr;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            instr_o.slot[i].valid = slot_valid_q[i];
            instr_o.slot[i].addr  = slot_addr_q[i];
            instr_o.slot[i].instr = slot_instr_q[i];
        end
    end

    // high while the front half of a straddling instruction waits here
    assign serving_unaligned_o = held_q;

endmodule

//--- hdl/fetch_predecode.sv
`timescale 1ns/10ps

module fetch_predecode (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  realign_pkg::fetch_req_t fetch_i,
    output realign_pkg::predec_t    predec_o
);
    import realign_pkg::*;

    // compressed flag of each incoming halfword, before the register
    logic [HALVES-1:0] half_compressed;

    // stage 1 register, valid is control state and the rest is payload
    logic              valid_q;
    fetch_req_t        fetch_q;
    logic [HALVES-1:0] compressed_q;

    // ----------------------------------------------------------------------
    // halfword classification
    // ----------------------------------------------------------------------

    // a halfword starts a full 32-bit instruction only when its two low
    // bits are both one, every other pattern is a compressed encoding
    // the upper halfword is classified too, even though it may turn out
    // to be the second half of a full instruction, stage 2 sorts that out
    always_comb begin
        for (int i = 0; i < HALVES; i++) begin
            half_compressed[i] = ~&fetch_i.data.half[i][1:0];
        end
    end

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------

    // the valid bit follows the strobe one cycle later
    // a fetch sampled together with a flush belongs to the old stream,
    // so it never enters the pipeline
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i && !flush_i;
        end
    end

    // address, data and flags only load on a strobe, so an idle cycle
    // keeps the last word and saves toggling in stage 2
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            fetch_q      <= fetch_i;
            compressed_q <= half_compressed;
        end
    end

    // hand the registered word to the realigner
    assign predec_o.valid           = valid_q;
    assign predec_o.addr            = fetch_q.addr;
    assign predec_o.data            = fetch_q.data;
    assign predec_o.half_compressed = compressed_q;

endmodule

//--- hdl/realign_pkg.sv
package realign_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------

    // instruction address width
    localparam int unsigned VLEN = 32;
    // instruction word width, also the fetch width of this front end
    localparam int unsigned ILEN = 32;
    // a compressed instruction occupies one halfword
    localparam int unsigned HALF_W = 16;
    // number of halfwords that arrive with each fetch word
    localparam int unsigned HALVES = ILEN / HALF_W;
    // the realigner can hand out at most this many instructions per cycle
    localparam int unsigned SLOTS = 2;

    // ----------------------------------------------------------------------
    // fetch word and pipeline records
    // ----------------------------------------------------------------------

    // one fetch word, read either as a full instruction or as its halfwords
    // half[0] is the lower halfword, which comes first in program order
    typedef union packed {
        logic [ILEN-1:0]                instr;
        logic [HALVES-1:0][HALF_W-1:0]  half;
    } fetch_word_u;

    // fetch as it is presented on the input ports
    typedef struct packed {
        logic [VLEN-1:0] addr;
        fetch_word_u     data;
    } fetch_req_t;

    // stage 1 record, the fetch plus the compressed flag of each halfword
    typedef struct packed {
        logic              valid;
        logic [VLEN-1:0]   addr;
        fetch_word_u       data;
        logic [HALVES-1:0] half_compressed;
    } predec_t;

    // one realigned instruction together with its own address
    typedef struct packed {
        logic            valid;
        logic [VLEN-1:0] addr;
        logic [ILEN-1:0] instr;
    } instr_slot_t;

    // slot[0] is older than slot[1] in program order
    typedef struct packed {
        instr_slot_t [SLOTS-1:0] slot;
    } realign_out_t;

endpackage
